// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = booth_mult_tb
FILELIST  = booth_mult.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Regression passed

SOURCES   = $(shell cat $(FILELIST))
SIM_EXE   = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: booth_mult.f
mult_cfg_pkg.sv
mult_types_pkg.sv
booth_pp_stage.sv
csa_tree_stage.sv
prefix_add_stage.sv
booth_mult_top.sv
booth_mult_tb.sv

// File: booth_mult_tb.sv
module booth_mult_tb;

   localparam int OW         = mult_cfg_pkg::OPERAND_W;
   localparam int PW         = mult_cfg_pkg::PRODUCT_W;
   localparam int DEPTH      = 3;
   localparam int WAIT_LIMIT = 50;
   localparam int STREAM_CNT = 200;
   localparam int GAP_CNT    = 100;
   localparam int IDLE_CNT   = 10;
   localparam int CORNER_CNT = 7;

   logic          CLK;
   logic          rst_n;
   logic          in_valid;
   logic [OW-1:0] multiplicand;
   logic [OW-1:0] multiplier;
   logic          out_valid;
   logic [PW-1:0] product;

   // Expected results with one slot per pipeline register
   logic [DEPTH-1:0] exp_valid;
   logic [PW-1:0]    exp_product [DEPTH];

   int          sent_count;
   int          out_count;
   logic [31:0] rng_state;

   // Covers every Booth digit including +2 and -2 and a nonzero top digit
   logic [OW-1:0] corner_vals [CORNER_CNT] =
      '{8'h00, 8'h01, 8'h55, 8'hAA, 8'h80, 8'hFF, 8'h7F};

   booth_mult_top i_dut (
      .CLK          (CLK),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .multiplicand (multiplicand),
      .multiplier   (multiplier),
      .out_valid    (out_valid),
      .product      (product)
   );

   initial CLK = 1'b0;
   always #2 CLK = ~CLK;

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         exp_valid <= '0;
      end else begin
         exp_valid <= {exp_valid[DEPTH-2:0], in_valid};
      end
   end

   always_ff @(posedge CLK) begin
      exp_product[0] <= PW'(multiplicand) * PW'(multiplier);
      for (int i = 1; i < DEPTH; i++) begin
         exp_product[i] <= exp_product[i-1];
      end
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         out_count <= 0;
      end else if (out_valid) begin
         out_count <= out_count + 1;
      end
   end

   task automatic abort_run();
      $display("Regression failed");
      $fatal(1, "Stopped at first error");
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   a_reset_quiet: assert property (@(posedge CLK) !rst_n |-> !out_valid)
      else begin
         $display("ERROR: out_valid in reset expected %h got %h", 1'b0, $sampled(out_valid));
         abort_run();
      end

   // Valid strobe must appear exactly three edges after its input strobe
   a_valid_match: assert property (@(posedge CLK) disable iff (!rst_n)
      out_valid == exp_valid[DEPTH-1])
      else begin
         $display("ERROR: out_valid expected %h got %h",
                  $sampled(exp_valid[DEPTH-1]), $sampled(out_valid));
         abort_run();
      end

   a_product_match: assert property (@(posedge CLK) disable iff (!rst_n)
      exp_valid[DEPTH-1] |-> product == exp_product[DEPTH-1])
      else begin
         $display("ERROR: product expected %h got %h",
                  $sampled(exp_product[DEPTH-1]), $sampled(product));
         abort_run();
      end

   task automatic drive_pair(input logic [OW-1:0] a, input logic [OW-1:0] b);
      @(posedge CLK);
      #1;
      in_valid     = 1'b1;
      multiplicand = a;
      multiplier   = b;
      sent_count++;
   endtask

   task automatic drive_idle();
      @(posedge CLK);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic wait_for_outputs(input int target);
      int cycles;
      cycles = 0;
      while (out_count != target && cycles <= WAIT_LIMIT) begin
         @(posedge CLK);
         #1;
         cycles++;
      end
      if (out_count != target) begin
         $display("Timeout after %0d cycles waiting for %0d products, only %0d arrived",
                  cycles, target, out_count);
         abort_run();
      end
   endtask

   initial begin
      int gap;
      int idle_start;

      rst_n        = 1'b0;
      in_valid     = 1'b0;
      multiplicand = '0;
      multiplier   = '0;
      sent_count   = 0;
      rng_state    = 32'h3656;

      repeat (5) @(posedge CLK);
      #1;
      rst_n = 1'b1;

      // Corner operands one at a time so each latency stands alone
      for (int i = 0; i < CORNER_CNT; i++) begin
         for (int j = 0; j < CORNER_CNT; j++) begin
            drive_pair(corner_vals[i], corner_vals[j]);
            drive_idle();
            wait_for_outputs(sent_count);
         end
      end

      // Back-to-back stream keeps three products in flight
      for (int n = 0; n < STREAM_CNT; n++) begin
         rng_state = xorshift32(rng_state);
         drive_pair(rng_state[7:0], rng_state[15:8]);
      end
      drive_idle();
      wait_for_outputs(sent_count);

      // Random gaps of 0 to 3 idle cycles between strobes
      for (int n = 0; n < GAP_CNT; n++) begin
         rng_state = xorshift32(rng_state);
         drive_pair(rng_state[7:0], rng_state[15:8]);
         gap = int'(rng_state[17:16]);
         repeat (gap) drive_idle();
      end
      drive_idle();
      wait_for_outputs(sent_count);

      idle_start = out_count;
      repeat (IDLE_CNT) drive_idle();

      if (out_count != idle_start) begin
         $display("Output strobe seen during %0d idle cycles after the last input", IDLE_CNT);
         abort_run();
      end else begin
         $display("Regression passed");
         $finish;
      end
   end

endmodule

// File: booth_mult_top.sv
module booth_mult_top (
   input  logic                               CLK,
   input  logic                               rst_n,
   input  logic                               in_valid,
   input  logic [mult_cfg_pkg::OPERAND_W-1:0] multiplicand,
   input  logic [mult_cfg_pkg::OPERAND_W-1:0] multiplier,
   output logic                               out_valid,
   output logic [mult_cfg_pkg::PRODUCT_W-1:0] product
);

   mult_types_pkg::pp_bundle_t pp_w;
   mult_types_pkg::csa_pair_t  csa_w;

   // Recoding and partial-product selection
   booth_pp_stage u_pp (
      .CLK          (CLK),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .multiplicand (multiplicand),
      .multiplier   (multiplier),
      .pp_out       (pp_w)
   );

   // Carry-save reduction to two rows
   csa_tree_stage u_csa (
      .CLK     (CLK),
      .rst_n   (rst_n),
      .pp_in   (pp_w),
      .csa_out (csa_w)
   );

   // Final carry-propagate add
   prefix_add_stage u_add (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .csa_in    (csa_w),
      .out_valid (out_valid),
      .product   (product)
   );

endmodule

// File: booth_pp_stage.sv
module booth_pp_stage (
   input  logic                                  CLK,
   input  logic                                  rst_n,
   input  logic                                  in_valid,
   input  logic [mult_cfg_pkg::OPERAND_W-1:0]    multiplicand,
   input  logic [mult_cfg_pkg::OPERAND_W-1:0]    multiplier,
   output mult_types_pkg::pp_bundle_t            pp_out
);

   localparam int NG   = mult_cfg_pkg::GROUP_CNT;
   localparam int PP_W = mult_cfg_pkg::PP_W;

   // Zero below bit 0, zeros above the top bit
   logic [2*NG:0]                     mcand_ext;
   mult_types_pkg::booth_op_e         op [NG];
   logic [PP_W-1:0]                   pp_mag [NG];
   logic [NG-1:0]                     neg_d;
   mult_types_pkg::pp_row_t [NG-1:0]  rows_d;

   logic                              valid_q;
   logic [NG-1:0]                     neg_q;
   mult_types_pkg::pp_row_t [NG-1:0]  rows_q;

   function automatic mult_types_pkg::booth_op_e booth_decode(input logic [2:0] grp);
      mult_types_pkg::booth_op_e digit;
      case (grp)
         3'b001, 3'b010: digit = mult_types_pkg::BOOTH_POS1;
         3'b011:         digit = mult_types_pkg::BOOTH_POS2;
         3'b100:         digit = mult_types_pkg::BOOTH_NEG2;
         3'b101, 3'b110: digit = mult_types_pkg::BOOTH_NEG1;
         default:        digit = mult_types_pkg::BOOTH_ZERO;
      endcase
      return digit;
   endfunction

   assign mcand_ext = {{(2 * NG - mult_cfg_pkg::OPERAND_W){1'b0}}, multiplicand, 1'b0};

   always_comb begin
      for (int j = 0; j < NG; j++) begin
         // Overlapping groups {m[2j+1], m[2j], m[2j-1]}
         op[j]    = booth_decode(mcand_ext[2*j +: 3]);
         neg_d[j] = op[j] inside {mult_types_pkg::BOOTH_NEG1, mult_types_pkg::BOOTH_NEG2};

         case (op[j])
            mult_types_pkg::BOOTH_POS1,
            mult_types_pkg::BOOTH_NEG1: pp_mag[j] = {1'b0, multiplier};
            mult_types_pkg::BOOTH_POS2,
            mult_types_pkg::BOOTH_NEG2: pp_mag[j] = {multiplier, 1'b0};
            default:                    pp_mag[j] = '0;
         endcase

         if (j < NG - 1) begin
            // Ones' complement here, the +1 rides on the negate bit
            rows_d[j] = {~neg_d[j], pp_mag[j] ^ {PP_W{neg_d[j]}}};
         end else begin
            // Top digit is 0 or +1, so the low byte is enough
            rows_d[j] = mult_types_pkg::pp_row_t'(pp_mag[j][mult_cfg_pkg::OPERAND_W-1:0]);
         end
      end
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= in_valid;
      end
   end

   always_ff @(posedge CLK) begin
      rows_q <= rows_d;
      neg_q  <= neg_d;
   end

   assign pp_out = '{valid: valid_q, rows: rows_q, neg: neg_q};

   a_valid_known: assert property (@(posedge CLK) disable iff (!rst_n)
      !$isunknown(valid_q));

endmodule

// File: csa_tree_stage.sv
module csa_tree_stage (
   input  logic                        CLK,
   input  logic                        rst_n,
   input  mult_types_pkg::pp_bundle_t  pp_in,
   output mult_types_pkg::csa_pair_t   csa_out
);

   localparam int NG = mult_cfg_pkg::GROUP_CNT;
   localparam int W  = mult_cfg_pkg::CSA_W;

   mult_types_pkg::csa_vec_t corr;
   mult_types_pkg::csa_vec_t row [NG];

   // Level outputs, carries already shifted to their weight
   mult_types_pkg::csa_vec_t s1, c1;
   mult_types_pkg::csa_vec_t s2, c2;
   mult_types_pkg::csa_vec_t s3, c3;
   mult_types_pkg::csa_vec_t s4, c4;

   logic                     valid_q;
   mult_types_pkg::csa_vec_t sum_q;
   mult_types_pkg::csa_vec_t carry_q;

   function automatic logic [1:0] full_add(input logic a, input logic b, input logic c);
      logic t;
      t = a ^ b;
      return {(a & b) | (t & c), t ^ c};
   endfunction

   function automatic logic [1:0] half_add(input logic a, input logic b);
      return {a & b, a ^ b};
   endfunction

   // One carry-save level over three rows.
   // Full adders only in columns lo..hi where all three rows overlap;
   // outside that window b and c never hold bits in the same column.
   function automatic logic [2*W-1:0] csa3(
      input mult_types_pkg::csa_vec_t a,
      input mult_types_pkg::csa_vec_t b,
      input mult_types_pkg::csa_vec_t c,
      input int                       lo,
      input int                       hi
   );
      mult_types_pkg::csa_vec_t s;
      mult_types_pkg::csa_vec_t co;
      logic [1:0]               r;
      co = '0;
      for (int i = 0; i < W; i++) begin
         if (i >= lo && i <= hi) begin
            r = full_add(a[i], b[i], c[i]);
         end else begin
            r = half_add(a[i], b[i] | c[i]);
         end
         s[i] = r[0];
         // Carry out of the top column is beyond the product
         if (i < W - 1) begin
            co[i+1] = r[1];
         end
      end
      return {co, s};
   endfunction

   // Correction row with the +1 of every negative row at its even position
   always_comb begin
      corr = mult_cfg_pkg::CORR_CONST;
      for (int j = 0; j < NG - 1; j++) begin
         corr[2*j] = pp_in.neg[j];
      end
   end

   always_comb begin
      for (int j = 0; j < NG; j++) begin
         row[j] = mult_types_pkg::csa_vec_t'(pp_in.rows[j]) << (2 * j);
      end
   end

   // Six rows to four: correction with rows 0 and 1, rows 2 to 4
   assign {c1, s1} = csa3(corr, row[0], row[1], 2, 9);
   assign {c2, s2} = csa3(row[3], row[2], row[4], 8, 13);

   // Four to three, c2 waits a level
   assign {c3, s3} = csa3(s1, c1, s2, 4, 12);

   // Three to two; carries start at bit 3
   assign {c4, s4} = csa3(s3, c3, c2, 7, 15);

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= pp_in.valid;
      end
   end

   always_ff @(posedge CLK) begin
      sum_q   <= s4;
      carry_q <= c4;
   end

   assign csa_out = '{valid: valid_q, sum: sum_q, carry: carry_q};

   // An unsigned multiplicand never yields a negative top digit
   a_top_digit_pos: assert property (@(posedge CLK) disable iff (!rst_n)
      pp_in.valid |-> !pp_in.neg[NG-1]);

endmodule

// File: mult_cfg_pkg.sv
package mult_cfg_pkg;

   // Operand and result widths
   localparam int OPERAND_W = 8;
   localparam int PRODUCT_W = 2 * OPERAND_W;

   // Radix-4 digits plus one more to cover the top bit of an unsigned multiplicand
   localparam int GROUP_CNT = OPERAND_W / 2 + 1;

   // Selected multiple, up to twice the multiplier
   localparam int PP_W = OPERAND_W + 1;

   // Selected multiple with its inverted sign bit on top
   localparam int ROW_W = PP_W + 1;

   // Carry-save vectors span the full product
   localparam int CSA_W = PRODUCT_W;

   // Upper part of the correction row that replaces all sign extension.
   // It is -(2^9) * (1 + 4 + 16 + 64) modulo 2^16.
   localparam logic [CSA_W-1:0] CORR_CONST = {7'b0101011, {(CSA_W - 7){1'b0}}};

endpackage

// File: mult_types_pkg.sv
package mult_types_pkg;

   // Radix-4 Booth digit, bit 2 marks a negative digit
   typedef enum logic [2:0] {
      BOOTH_ZERO = 3'b000,
      BOOTH_POS1 = 3'b001,
      BOOTH_POS2 = 3'b010,
      BOOTH_NEG1 = 3'b101,
      BOOTH_NEG2 = 3'b110
   } booth_op_e;

   // One partial-product row, right aligned at its own weight
   typedef logic [mult_cfg_pkg::ROW_W-1:0] pp_row_t;

   // Weight-aligned carry-save vector
   typedef logic [mult_cfg_pkg::CSA_W-1:0] csa_vec_t;

   // Recoding stage to reduction stage.
   // Row j has weight 4^j; the last row uses only its low byte.
   typedef struct packed {
      logic                                 valid;
      pp_row_t [mult_cfg_pkg::GROUP_CNT-1:0] rows;
      logic [mult_cfg_pkg::GROUP_CNT-1:0]    neg;
   } pp_bundle_t;

   // Reduction stage to adder stage
   typedef struct packed {
      logic     valid;
      csa_vec_t sum;
      csa_vec_t carry;
   } csa_pair_t;

endpackage

// File: prefix_add_stage.sv
module prefix_add_stage (
   input  logic                               CLK,
   input  logic                               rst_n,
   input  mult_types_pkg::csa_pair_t          csa_in,
   output logic                               out_valid,
   output logic [mult_cfg_pkg::PRODUCT_W-1:0] product
);

   // Lowest column that can receive a carry from the reduction tree
   localparam int CARRY_LSB = 3;
   localparam int ADD_W     = mult_cfg_pkg::CSA_W - CARRY_LSB;
   localparam int LEVELS    = 4;

   logic [ADD_W-1:0] op_a;
   logic [ADD_W-1:0] op_b;
   logic [ADD_W-1:0] gen [LEVELS+1];
   logic [ADD_W-1:0] prp [LEVELS+1];
   logic [ADD_W-1:0] upper_sum;

   assign op_a = csa_in.sum[mult_cfg_pkg::CSA_W-1:CARRY_LSB];
   assign op_b = csa_in.carry[mult_cfg_pkg::CSA_W-1:CARRY_LSB];

   // Prefix tree with spans 1, 2, 4, 8.
   // After the last level gen[i] is the carry out of bits 0..i.
   always_comb begin
      gen[0] = op_a & op_b;
      prp[0] = op_a | op_b;
      for (int lvl = 0; lvl < LEVELS; lvl++) begin
         for (int i = 0; i < ADD_W; i++) begin
            if (i >= (1 << lvl)) begin
               gen[lvl+1][i] = gen[lvl][i] | (prp[lvl][i] & gen[lvl][i - (1 << lvl)]);
               prp[lvl+1][i] = prp[lvl][i] & prp[lvl][i - (1 << lvl)];
            end else begin
               gen[lvl+1][i] = gen[lvl][i];
               prp[lvl+1][i] = prp[lvl][i];
            end
         end
      end
   end

   // No carry into the lowest added bit, top carry out is dropped
   assign upper_sum = op_a ^ op_b ^ {gen[LEVELS][ADD_W-2:0], 1'b0};

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= csa_in.valid;
      end
   end

   always_ff @(posedge CLK) begin
      product <= {upper_sum, csa_in.sum[CARRY_LSB-1:0]};
   end

   a_out_valid_known: assert property (@(posedge CLK) disable iff (!rst_n)
      !$isunknown(out_valid));

endmodule
